//--- verilog/mips_isa_pkg.sv
package mips_isa_pkg;

	////////////////////////////////////////////////////////////
	// Machine word and register file geometry
	////////////////////////////////////////////////////////////
	localparam int data_width     = 32; // Machine word
	localparam int reg_count      = 32; // Architectural registers
	localparam int reg_addr_width = 5;  // Register index
	localparam int imm_width      = 16; // I-type immediate field

	////////////////////////////////////////////////////////////
	// Instruction field layout
	////////////////////////////////////////////////////////////
	localparam int op_width    = 6;
	localparam int funct_width = 6;
	localparam int shamt_width = 5;
	localparam int op_lsb      = 26; // instr[31:26]
	localparam int rs_lsb      = 21; // instr[25:21]
	localparam int rt_lsb      = 16; // instr[20:16]
	localparam int rd_lsb      = 11; // instr[15:11]
	localparam int shamt_lsb   = 6;  // instr[10:6]

	////////////////////////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////////////////////////
	localparam logic [op_width-1:0] op_rtype = 6'b000000; // Selects on funct
	localparam logic [op_width-1:0] op_addi  = 6'b001000;
	localparam logic [op_width-1:0] op_andi  = 6'b001100;
	localparam logic [op_width-1:0] op_ori   = 6'b001101;
	localparam logic [op_width-1:0] op_lui   = 6'b001111;
	localparam logic [op_width-1:0] op_lw    = 6'b100011;
	localparam logic [op_width-1:0] op_sw    = 6'b101011;
	localparam logic [op_width-1:0] op_beq   = 6'b000100;

	// R-type funct codes
	localparam logic [funct_width-1:0] fn_add = 6'b100000;
	localparam logic [funct_width-1:0] fn_sub = 6'b100010;
	localparam logic [funct_width-1:0] fn_and = 6'b100100;
	localparam logic [funct_width-1:0] fn_or  = 6'b100101;
	localparam logic [funct_width-1:0] fn_slt = 6'b101010;
	localparam logic [funct_width-1:0] fn_sll = 6'b000000; // Shift by shamt

endpackage

//--- verilog/decode_ctrl_pkg.sv
package decode_ctrl_pkg;

	////////////////////////////////////////////////////////////
	// Decoded control word, as seen by execute and memory
	////////////////////////////////////////////////////////////

	localparam int alu_op_width = 3; // Room for eight operations

	// ALU operation selected by decode
	typedef enum logic [alu_op_width-1:0] {
		alu_add = 3'd0, // add, addi, lw and sw address
		alu_sub = 3'd1, // sub, beq compare
		alu_and = 3'd2, // and, andi
		alu_or  = 3'd3, // or, ori
		alu_slt = 3'd4, // Signed set on less than
		alu_sll = 3'd5, // Shift rt left by shamt
		alu_lui = 3'd6  // Pass the shifted immediate
	} alu_op_t;

	// The remaining control bits travel as single-bit ports
	//   alu_src_imm  second ALU operand from imm_ext
	//   mem_read     load from data memory
	//   mem_write    store rt to data memory
	//   reg_write    result written to dest_reg
	//   branch       compare for beq
	//   illegal      unknown opcode or funct

endpackage

//--- verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file
(
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic                                   write_enable,
	input  logic [mips_isa_pkg::reg_addr_width-1:0] write_reg,
	input  logic [mips_isa_pkg::data_width-1:0]     write_data,
	input  logic [mips_isa_pkg::reg_addr_width-1:0] read_reg_1,
	input  logic [mips_isa_pkg::reg_addr_width-1:0] read_reg_2,
	output logic [mips_isa_pkg::data_width-1:0]     read_data_1,
	output logic [mips_isa_pkg::data_width-1:0]     read_data_2
);

	import mips_isa_pkg::*;

	logic [data_width-1:0] regs [reg_count]; // Register array

	////////////////////////////////////////////////////////////
	// Write port, falling edge
	////////////////////////////////////////////////////////////

	// Writing on the falling edge puts a writeback ahead of the
	// read sample at the next rising edge of the same cycle
	always_ff @(negedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < reg_count; i++)
			begin
				regs[i] <= '0; // Clear whole array
			end
		end
		else if (write_enable && (write_reg != '0))
		begin
			regs[write_reg] <= write_data; // r0 stays untouched
		end
	end

	////////////////////////////////////////////////////////////
	// Read ports, rising edge
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			read_data_1 <= '0;
			read_data_2 <= '0;
		end
		else
		begin
			read_data_1 <= (read_reg_1 == '0) ? '0 : regs[read_reg_1]; // r0 reads zero
			read_data_2 <= (read_reg_2 == '0) ? '0 : regs[read_reg_2];
		end
	end

endmodule

//--- verilog/control_decoder.sv
`timescale 1ns/1ps

module control_decoder
(
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic                                   instr_valid,
	input  logic [mips_isa_pkg::data_width-1:0]     instr,
	output logic                                   out_valid,
	output decode_ctrl_pkg::alu_op_t               alu_op,
	output logic                                   alu_src_imm,
	output logic                                   mem_read,
	output logic                                   mem_write,
	output logic                                   reg_write,
	output logic                                   branch,
	output logic                                   illegal,
	output logic [mips_isa_pkg::data_width-1:0]     imm_ext,
	output logic [mips_isa_pkg::reg_addr_width-1:0] dest_reg,
	output logic [mips_isa_pkg::shamt_width-1:0]    shamt,
	output logic [mips_isa_pkg::reg_addr_width-1:0] rs,
	output logic [mips_isa_pkg::reg_addr_width-1:0] rt
);

	import mips_isa_pkg::*;
	import decode_ctrl_pkg::*;

	logic [op_width-1:0]       opcode;
	logic [funct_width-1:0]    funct;
	logic [reg_addr_width-1:0] rd;
	logic [imm_width-1:0]      imm;

	alu_op_t                   dec_alu_op;
	logic                      dec_src_imm;
	logic                      dec_mem_read;
	logic                      dec_mem_write;
	logic                      dec_reg_write;
	logic                      dec_branch;
	logic                      dec_illegal;
	logic [reg_addr_width-1:0] dec_dest;
	logic [data_width-1:0]     dec_imm;

	// Field split, rs and rt go straight to the register file
	assign opcode = instr[op_lsb +: op_width];
	assign rs     = instr[rs_lsb +: reg_addr_width];
	assign rt     = instr[rt_lsb +: reg_addr_width];
	assign rd     = instr[rd_lsb +: reg_addr_width];
	assign funct  = instr[funct_width-1:0];
	assign imm    = instr[imm_width-1:0];

	////////////////////////////////////////////////////////////
	// Control word
	////////////////////////////////////////////////////////////

	always_comb
	begin
		dec_alu_op    = alu_add; // Default, address arithmetic
		dec_src_imm   = 1'b0;
		dec_mem_read  = 1'b0;
		dec_mem_write = 1'b0;
		dec_reg_write = 1'b0;
		dec_branch    = 1'b0;
		dec_illegal   = 1'b0;
		dec_dest      = rt; // I-type destination
		case (opcode)
			op_rtype:
			begin
				dec_dest      = rd;
				dec_reg_write = 1'b1;
				case (funct)
					fn_add:  dec_alu_op = alu_add;
					fn_sub:  dec_alu_op = alu_sub;
					fn_and:  dec_alu_op = alu_and;
					fn_or:   dec_alu_op = alu_or;
					fn_slt:  dec_alu_op = alu_slt;
					fn_sll:  dec_alu_op = alu_sll;
					default: dec_illegal = 1'b1; // Unknown funct
				endcase
			end
			op_addi: {dec_src_imm, dec_reg_write} = 2'b11;
			op_andi:
			begin
				dec_alu_op = alu_and;
				{dec_src_imm, dec_reg_write} = 2'b11;
			end
			op_ori:
			begin
				dec_alu_op = alu_or;
				{dec_src_imm, dec_reg_write} = 2'b11;
			end
			op_lui:
			begin
				dec_alu_op = alu_lui;
				{dec_src_imm, dec_reg_write} = 2'b11;
			end
			op_lw:   {dec_src_imm, dec_mem_read, dec_reg_write} = 3'b111;
			op_sw:   {dec_src_imm, dec_mem_write} = 2'b11; // No register result
			op_beq:
			begin
				dec_alu_op = alu_sub; // Compare rs against rt
				dec_branch = 1'b1;
			end
			default: dec_illegal = 1'b1; // Unknown opcode
		endcase
		if (dec_illegal)
		begin
			// Nothing may change state for a bad encoding
			{dec_src_imm, dec_mem_read, dec_mem_write, dec_reg_write, dec_branch} = '0;
		end
	end

	// Immediate extension
	always_comb
	begin
		case (opcode)
			op_andi, op_ori: dec_imm = {{(data_width-imm_width){1'b0}}, imm}; // Zero
			op_lui:          dec_imm = {imm, {(data_width-imm_width){1'b0}}}; // Upper half
			default:         dec_imm = {{(data_width-imm_width){imm[imm_width-1]}}, imm};
		endcase
	end

	////////////////////////////////////////////////////////////
	// Output registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out_valid   <= 1'b0;
			alu_src_imm <= 1'b0;
			mem_read    <= 1'b0;
			mem_write   <= 1'b0;
			reg_write   <= 1'b0;
			branch      <= 1'b0;
			illegal     <= 1'b0;
		end
		else
		begin
			out_valid   <= instr_valid; // One cycle per strobe
			alu_src_imm <= instr_valid & dec_src_imm;
			mem_read    <= instr_valid & dec_mem_read;
			mem_write   <= instr_valid & dec_mem_write;
			reg_write   <= instr_valid & dec_reg_write;
			branch      <= instr_valid & dec_branch;
			illegal     <= instr_valid & dec_illegal;
		end
	end

	// Payload held until the next strobe
	always_ff @(posedge clk)
	begin
		if (instr_valid)
		begin
			alu_op   <= dec_alu_op;
			imm_ext  <= dec_imm;
			dest_reg <= dec_dest;
			shamt    <= instr[shamt_lsb +: shamt_width];
		end
	end

endmodule

//--- verilog/hazard_detect.sv
`timescale 1ns/1ps

module hazard_detect
(
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               instr_valid,
	input  logic [mips_isa_pkg::data_width-1:0] instr,
	output logic                               load_use_stall
);

	import mips_isa_pkg::*;

	logic [op_width-1:0]       opcode;
	logic [reg_addr_width-1:0] rs;
	logic [reg_addr_width-1:0] rt;
	logic                      reads_rt; // Instruction uses rt as a source
	logic                      hit;      // Source matches pending load
	logic                      armed;    // Last accepted instr was a load
	logic [reg_addr_width-1:0] load_reg; // Its destination

	assign opcode = instr[op_lsb +: op_width];
	assign rs     = instr[rs_lsb +: reg_addr_width];
	assign rt     = instr[rt_lsb +: reg_addr_width];

	// rs is read by every format, rt only by these three
	assign reads_rt = (opcode == op_rtype) || (opcode == op_sw) || (opcode == op_beq);
	assign hit      = armed && ((rs == load_reg) || (reads_rt && (rt == load_reg)));

	////////////////////////////////////////////////////////////
	// Pending load tracking
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			armed          <= 1'b0;
			load_use_stall <= 1'b0;
		end
		else
		begin
			load_use_stall <= instr_valid & hit; // Aligned with decoder outputs
			if (instr_valid)
			begin
				armed <= (opcode == op_lw) && (rt != '0); // Load to r0 is harmless
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (instr_valid)
		begin
			load_reg <= rt; // Only meaningful while armed
		end
	end

endmodule

//--- verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
(
	input  logic                                   clk,
	input  logic                                   reset,
	// Instruction from fetch
	input  logic                                   instr_valid,
	input  logic [mips_isa_pkg::data_width-1:0]     instr,
	// Writeback from the end of the pipe
	input  logic                                   wb_valid,
	input  logic [mips_isa_pkg::reg_addr_width-1:0] wb_reg,
	input  logic [mips_isa_pkg::data_width-1:0]     wb_data,
	// Operands and payload
	output logic [mips_isa_pkg::data_width-1:0]     read_data_1,
	output logic [mips_isa_pkg::data_width-1:0]     read_data_2,
	output logic [mips_isa_pkg::data_width-1:0]     imm_ext,
	output logic [mips_isa_pkg::reg_addr_width-1:0] dest_reg,
	output logic [mips_isa_pkg::shamt_width-1:0]    shamt,
	// Control word
	output logic                                   out_valid,
	output decode_ctrl_pkg::alu_op_t               alu_op,
	output logic                                   alu_src_imm,
	output logic                                   mem_read,
	output logic                                   mem_write,
	output logic                                   reg_write,
	output logic                                   branch,
	output logic                                   illegal,
	output logic                                   load_use_stall
);

	import mips_isa_pkg::*;

	logic [reg_addr_width-1:0] rs; // Source addresses from the decoder
	logic [reg_addr_width-1:0] rt;

	////////////////////////////////////////////////////////////
	// All three units register on the same rising edge
	////////////////////////////////////////////////////////////

	control_decoder u_control_decoder
	(
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.out_valid   (out_valid),
		.alu_op      (alu_op),
		.alu_src_imm (alu_src_imm),
		.mem_read    (mem_read),
		.mem_write   (mem_write),
		.reg_write   (reg_write),
		.branch      (branch),
		.illegal     (illegal),
		.imm_ext     (imm_ext),
		.dest_reg    (dest_reg),
		.shamt       (shamt),
		.rs          (rs),
		.rt          (rt)
	);

	reg_file u_reg_file
	(
		.clk          (clk),
		.reset        (reset),
		.write_enable (wb_valid), // r0 filtered inside
		.write_reg    (wb_reg),
		.write_data   (wb_data),
		.read_reg_1   (rs),
		.read_reg_2   (rt),
		.read_data_1  (read_data_1),
		.read_data_2  (read_data_2)
	);

	hazard_detect u_hazard_detect
	(
		.clk            (clk),
		.reset          (reset),
		.instr_valid    (instr_valid),
		.instr          (instr),
		.load_use_stall (load_use_stall) // Flag only, no stall applied here
	);

endmodule

//--- test/decode_stage_asserts.sv
`timescale 1ns/1ps

module decode_stage_asserts
(
	input logic                               clk,
	input logic                               reset,
	input logic                               instr_valid,
	input logic                               out_valid,
	input logic                               alu_src_imm,
	input logic                               mem_read,
	input logic                               mem_write,
	input logic                               reg_write,
	input logic                               branch,
	input logic                               illegal,
	input logic                               load_use_stall,
	input logic [mips_isa_pkg::data_width-1:0] read_data_1,
	input logic [mips_isa_pkg::data_width-1:0] read_data_2
);

	int fail_count = 0; // Failed assertions so far

	////////////////////////////////////////////////////////////
	// Reset state and strobe protocol
	////////////////////////////////////////////////////////////

	reset_clears: assert property (@(posedge clk) $past(reset) |->
		!out_valid && !alu_src_imm && !mem_read && !mem_write && !reg_write &&
		!branch && !illegal && !load_use_stall && (read_data_1 == '0) && (read_data_2 == '0))
		else begin fail_count++; $error("outputs not cleared by reset"); end

	valid_follows_strobe: assert property (@(posedge clk) disable iff (reset)
		!$past(reset) |-> (out_valid == $past(instr_valid)))
		else begin fail_count++; $error("out_valid does not follow instr_valid"); end

	mem_exclusive: assert property (@(posedge clk) !(mem_read && mem_write))
		else begin fail_count++; $error("mem_read and mem_write both high"); end

	// Bad encodings must not touch state
	illegal_quiet: assert property (@(posedge clk) illegal |->
		!reg_write && !mem_read && !mem_write)
		else begin fail_count++; $error("illegal with a write enable set"); end

	stall_with_valid: assert property (@(posedge clk) load_use_stall |-> out_valid)
		else begin fail_count++; $error("load_use_stall without out_valid"); end

endmodule

bind decode_stage decode_stage_asserts u_asserts
(
	.clk            (clk),
	.reset          (reset),
	.instr_valid    (instr_valid),
	.out_valid      (out_valid),
	.alu_src_imm    (alu_src_imm),
	.mem_read       (mem_read),
	.mem_write      (mem_write),
	.reg_write      (reg_write),
	.branch         (branch),
	.illegal        (illegal),
	.load_use_stall (load_use_stall),
	.read_data_1    (read_data_1),
	.read_data_2    (read_data_2)
);

//--- test/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb;

	import mips_isa_pkg::*;
	import decode_ctrl_pkg::*;

	localparam int          clk_period   = 20;
	localparam int          reset_cycles = 16;
	localparam int          run_cycles   = 400;
	localparam int          timeout_ns   = (reset_cycles + run_cycles + 20) * clk_period;
	localparam logic [31:0] rand_seed    = 32'h2888_cbbf;

	logic                      clk;
	logic                      reset;
	logic                      instr_valid;
	logic [data_width-1:0]     instr;
	logic                      wb_valid;
	logic [reg_addr_width-1:0] wb_reg;
	logic [data_width-1:0]     wb_data;
	logic [data_width-1:0]     read_data_1;
	logic [data_width-1:0]     read_data_2;
	logic [data_width-1:0]     imm_ext;
	logic [reg_addr_width-1:0] dest_reg;
	logic [shamt_width-1:0]    shamt;
	logic                      out_valid;
	alu_op_t                   alu_op;
	logic                      alu_src_imm;
	logic                      mem_read;
	logic                      mem_write;
	logic                      reg_write;
	logic                      branch;
	logic                      illegal;
	logic                      load_use_stall;

	logic [data_width-1:0]     shadow [reg_count]; // Architectural register model
	logic                      exp_valid;          // Expectations for the next falling edge
	alu_op_t                   exp_alu;
	logic                      exp_src;
	logic                      exp_mr;
	logic                      exp_mw;
	logic                      exp_rw;
	logic                      exp_br;
	logic                      exp_ill;
	logic                      exp_stall;
	logic [reg_addr_width-1:0] exp_dest;
	logic [shamt_width-1:0]    exp_shamt;
	logic [data_width-1:0]     exp_imm;
	logic [data_width-1:0]     exp_rd1;
	logic [data_width-1:0]     exp_rd2;
	logic                      armed;              // Pending load seen by the model
	logic [reg_addr_width-1:0] load_reg;
	int                        check_count;
	int                        error_count;
	int                        seed_sink;

	decode_stage DUT
	(
		.clk            (clk),
		.reset          (reset),
		.instr_valid    (instr_valid),
		.instr          (instr),
		.wb_valid       (wb_valid),
		.wb_reg         (wb_reg),
		.wb_data        (wb_data),
		.read_data_1    (read_data_1),
		.read_data_2    (read_data_2),
		.imm_ext        (imm_ext),
		.dest_reg       (dest_reg),
		.shamt          (shamt),
		.out_valid      (out_valid),
		.alu_op         (alu_op),
		.alu_src_imm    (alu_src_imm),
		.mem_read       (mem_read),
		.mem_write      (mem_write),
		.reg_write      (reg_write),
		.branch         (branch),
		.illegal        (illegal),
		.load_use_stall (load_use_stall)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial
	begin
		#(timeout_ns);
		$display("timeout: the run did not reach its end in time");
		$display("Verification failed");
		$finish;
	end

	task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		assert (got === exp)
		else
		begin
			error_count++;
			$display("error at %0d ns: %s = %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Compare DUT outputs with the model
	////////////////////////////////////////////////////////////

	task automatic check_outputs();
		check_field("out_valid", out_valid, exp_valid);
		check_field("alu_src_imm", alu_src_imm, exp_valid & exp_src);
		check_field("mem_read", mem_read, exp_valid & exp_mr);
		check_field("mem_write", mem_write, exp_valid & exp_mw);
		check_field("reg_write", reg_write, exp_valid & exp_rw);
		check_field("branch", branch, exp_valid & exp_br);
		check_field("illegal", illegal, exp_valid & exp_ill);
		check_field("load_use_stall", load_use_stall, exp_valid & exp_stall);
		if (exp_valid)
		begin
			check_field("read_data_1", read_data_1, exp_rd1);
			check_field("read_data_2", read_data_2, exp_rd2);
			check_field("imm_ext", imm_ext, exp_imm);
			check_field("shamt", shamt, exp_shamt);
			if (!exp_ill)
				check_field("alu_op", alu_op, exp_alu);
			if (exp_rw)
				check_field("dest_reg", dest_reg, exp_dest); // Only defined when written
		end
	endtask

	////////////////////////////////////////////////////////////
	// One falling edge of stimulus and prediction
	////////////////////////////////////////////////////////////

	task automatic drive_cycle(input logic active);
		int                        kind;
		logic                      strobe;
		logic                      reads_rt;
		logic [reg_addr_width-1:0] rs;
		logic [reg_addr_width-1:0] rt;
		logic [reg_addr_width-1:0] rd;
		logic [shamt_width-1:0]    sh;
		logic [op_width-1:0]       op;
		logic [funct_width-1:0]    fn;
		logic [imm_width-1:0]      imm;
		logic [data_width-1:0]     word;
		logic [alu_op_width-1:0]   alu_code;
		// Writeback held since the last falling edge is written on this one
		if (wb_valid && (wb_reg != '0))
			shadow[wb_reg] = wb_data;
		strobe = active && ($urandom_range(0, 9) < 7); // Mix of runs and gaps
		kind   = $urandom_range(0, 14);
		rs     = $urandom_range(0, 7); // Small range so hazards happen often
		rt     = $urandom_range(0, 7);
		rd     = $urandom_range(0, 7);
		sh     = $urandom_range(0, 31);
		imm    = $urandom_range(0, 16'hffff);
		op     = op_rtype;
		fn     = fn_add;
		{exp_src, exp_mr, exp_mw, exp_rw, exp_br, exp_ill} = '0;
		alu_code = alu_add;
		case (kind)
			0: exp_rw = 1'b1; // add
			1: {fn, alu_code, exp_rw} = {fn_sub, alu_sub, 1'b1};
			2: {fn, alu_code, exp_rw} = {fn_and, alu_and, 1'b1};
			3: {fn, alu_code, exp_rw} = {fn_or, alu_or, 1'b1};
			4: {fn, alu_code, exp_rw} = {fn_slt, alu_slt, 1'b1};
			5: {fn, alu_code, exp_rw} = {fn_sll, alu_sll, 1'b1};
			6: {op, exp_src, exp_rw} = {op_addi, 2'b11};
			7: {op, alu_code, exp_src, exp_rw} = {op_andi, alu_and, 2'b11};
			8: {op, alu_code, exp_src, exp_rw} = {op_ori, alu_or, 2'b11};
			9: {op, alu_code, exp_src, exp_rw} = {op_lui, alu_lui, 2'b11};
			10: {op, exp_src, exp_mr, exp_rw} = {op_lw, 3'b111};
			11: {op, exp_src, exp_mw} = {op_sw, 2'b11};
			12: {op, alu_code, exp_br} = {op_beq, alu_sub, 1'b1};
			13: {op, exp_ill} = {($urandom_range(0, 1) ? 6'h02 : 6'h3f), 1'b1}; // j or unused
			default: {fn, exp_ill} = {6'h21, 1'b1}; // addu not supported
		endcase
		exp_alu = alu_op_t'(alu_code);
		word = (op == op_rtype) ? {op, rs, rt, rd, sh, fn} : {op, rs, rt, imm};
		imm  = word[15:0];
		if ((kind == 7) || (kind == 8))
			exp_imm = {16'h0000, imm};
		else if (kind == 9)
			exp_imm = {imm, 16'h0000};
		else
			exp_imm = {{16{imm[15]}}, imm};
		exp_dest  = ((kind <= 5) || (kind == 14)) ? rd : rt;
		exp_shamt = word[10:6];
		exp_rd1   = shadow[rs]; // r0 is never written in the model
		exp_rd2   = shadow[rt];
		reads_rt  = (kind <= 5) || (kind == 14) || (kind == 11) || (kind == 12);
		exp_stall = 1'b0;
		if (strobe)
		begin
			exp_stall = armed && ((rs == load_reg) || (reads_rt && (rt == load_reg)));
			armed     = (kind == 10) && (rt != '0); // Every accepted instr re-arms
			load_reg  = rt;
		end
		exp_valid = strobe;
		instr_valid <= strobe;
		instr       <= word;
		wb_valid    <= active && $urandom_range(0, 1);
		wb_reg      <= $urandom_range(0, 7); // Includes writes to r0
		wb_data     <= $urandom;
	endtask

	initial
	begin
		seed_sink   = $urandom(rand_seed);
		reset       = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		wb_valid    = 1'b0;
		wb_reg      = '0;
		wb_data     = '0;
		for (int i = 0; i < reg_count; i++)
			shadow[i] = '0;
		armed       = 1'b0;
		load_reg    = '0;
		exp_valid   = 1'b0;
		check_count = 0;
		error_count = 0;
		repeat (reset_cycles) @(negedge clk);
		reset <= 1'b0;
		for (int c = 0; c < run_cycles; c++)
		begin
			@(negedge clk);
			check_outputs();
			drive_cycle(1'b1);
		end
		repeat (2) // Drain the last strobe
		begin
			@(negedge clk);
			check_outputs();
			drive_cycle(1'b0);
		end
		$display("%0d checks, %0d value errors, %0d assertion errors",
			check_count, error_count, DUT.u_asserts.fail_count);
		if ((error_count == 0) && (DUT.u_asserts.fail_count == 0))
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- flist.f
verilog/mips_isa_pkg.sv
verilog/decode_ctrl_pkg.sv
verilog/reg_file.sv
verilog/control_decoder.sv
verilog/hazard_detect.sv
verilog/decode_stage.sv
test/decode_stage_asserts.sv
test/decode_stage_tb.sv
